/* design/deBoardPkg.sv */
/*
 * Shared types and constants for the board wrapper: the data bus request,
 * the decode and display enums, the peripheral address map and the timing
 * constants. Every design unit imports it.
 */
package deBoardPkg;

    // request side of the data bus, driven by the CPU
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] writeData;
        logic        readEnable;
        logic        writeEnable;
        logic [3:0]  byteEnable;
    } busReqT;

    // decode targets on the data bus
    typedef enum logic [2:0] {
        selNone,
        selStopwatch,
        selLfsr,
        selBreakAddr,
        selBreakCtrl
    } periphSelT;

    // word shown on the displays, encoded as sw[9:8]
    typedef enum logic [1:0] {
        dispZero,
        dispDebug,
        dispInstr,
        dispPc
    } displaySrcT;

    // clock control modes
    typedef enum logic [1:0] {
        modeRun,
        modeStep,
        modeHalted
    } runModeT;

    // six active-low digits, digit 0 is the rightmost
    typedef logic [5:0][6:0] hexDigitsT;

    // memory-mapped I/O addresses
    localparam logic [31:0] stopwatchAddr = 32'hFF20_0510;
    localparam logic [31:0] lfsrAddr      = 32'hFF20_0514;
    localparam logic [31:0] breakAddrAddr = 32'hFF20_0600;
    localparam logic [31:0] breakCtrlAddr = 32'hFF20_0604;

    // galois feedback mask
    localparam logic [31:0] lfsrTaps = 32'h8020_0003;

    // 50 MHz cycles per microsecond
    localparam int cyclesPerUs = 50;
    localparam int syncStages  = 2;

    // replace the enabled byte lanes of oldWord with those of newWord
    function automatic logic [31:0] mergeBytes(input logic [31:0] oldWord,
                                               input logic [31:0] newWord,
                                               input logic [3:0]  byteEnable);
        logic [31:0] merged;
        merged = oldWord;
        for (int i = 0; i < 4; i++) begin
            if (byteEnable[i]) begin
                merged[8*i +: 8] = newWord[8*i +: 8];
            end
        end
        return merged;
    endfunction

endpackage

/* design/clockControl.sv */
/*
 * CPU clock control. Synchronizes the push buttons, runs the run/step/halt
 * mode machine and emits a one-cycle tick strobe on CLOCK_50 in place of a
 * derived CPU clock.
 */
`timescale 1ns/10ps

module clockControl import deBoardPkg::*; (
    input  logic       CLOCK_50,
    input  logic       arstN,
    input  logic [3:0] key,
    input  logic [4:0] divisor,
    input  logic       halt,
    output logic       tick,
    output runModeT    mode
);

    // keys are active low, so the synchronizer idles at ones
    logic [syncStages-1:0][3:0] keySync;
    logic [3:0] keyLast;
    logic [3:0] press;
    logic [4:0] divCount;
    runModeT    resumeMode;

    always_ff @(posedge CLOCK_50 or negedge arstN) begin
        if (!arstN) begin
            keySync <= '1;
            keyLast <= '1;
        end else begin
            keySync[0] <= key;
            for (int i = 1; i < syncStages; i++) begin
                keySync[i] <= keySync[i-1];
            end
            keyLast <= keySync[syncStages-1];
        end
    end

    // falling edge of a synced key is a press
    assign press = keyLast & ~keySync[syncStages-1];

    // mode FSM, a break halt wins over the buttons
    always_ff @(posedge CLOCK_50 or negedge arstN) begin
        if (!arstN) begin
            mode       <= modeRun;
            resumeMode <= modeRun;
        end else begin
            case (mode)
                modeRun, modeStep: begin
                    if (halt) begin
                        // remember where to go back after key[3]
                        resumeMode <= mode;
                        mode       <= modeHalted;
                    end else if (press[1]) begin
                        mode <= (mode == modeRun) ? modeStep : modeRun;
                    end
                end
                modeHalted: begin
                    if (press[3]) begin
                        mode <= resumeMode;
                    end
                end
                default: mode <= modeRun;
            endcase
        end
    end

    // tick every divisor+1 cycles in run, one per key[2] press in step
    always_ff @(posedge CLOCK_50 or negedge arstN) begin
        if (!arstN) begin
            divCount <= '0;
            tick     <= 1'b0;
        end else begin
            tick <= 1'b0;
            if (mode == modeRun) begin
                if (divCount >= divisor) begin
                    divCount <= '0;
                    tick     <= !halt;
                end else begin
                    divCount <= divCount + 5'd1;
                end
            end else begin
                divCount <= '0;
                if (mode == modeStep) begin
                    tick <= press[2] && !halt;
                end
            end
        end
    end

    // the CPU must stay frozen while halted
    noTickWhenHalted: assert property (@(posedge CLOCK_50) disable iff (!arstN)
        mode == modeHalted |-> !tick);

endmodule

/* design/busDecoder.sv */
/*
 * Data bus decoder. Turns the bus address into read and write select
 * strobes and returns the selected peripheral word one cycle after a read.
 */
`timescale 1ns/10ps

module busDecoder import deBoardPkg::*; (
    input  logic        CLOCK_50,
    input  logic        arstN,
    input  busReqT      busReq,
    input  logic [31:0] stopwatchData,
    input  logic [31:0] lfsrData,
    input  logic [31:0] breakAddrData,
    input  logic [31:0] breakCtrlData,
    output periphSelT   readSel,
    output periphSelT   writeSel,
    output logic [31:0] readData
);

    periphSelT addrSel;

    // full-word compare, anything else is unmapped
    always_comb begin
        case (busReq.addr)
            stopwatchAddr: addrSel = selStopwatch;
            lfsrAddr:      addrSel = selLfsr;
            breakAddrAddr: addrSel = selBreakAddr;
            breakCtrlAddr: addrSel = selBreakCtrl;
            default:       addrSel = selNone;
        endcase
    end

    assign readSel  = busReq.readEnable  ? addrSel : selNone;
    assign writeSel = busReq.writeEnable ? addrSel : selNone;

    // read data held until the next read
    always_ff @(posedge CLOCK_50 or negedge arstN) begin
        if (!arstN) begin
            readData <= '0;
        end else if (busReq.readEnable) begin
            case (addrSel)
                selStopwatch: readData <= stopwatchData;
                selLfsr:      readData <= lfsrData;
                selBreakAddr: readData <= breakAddrData;
                selBreakCtrl: readData <= breakCtrlData;
                default:      readData <= '0;
            endcase
        end
    end

    readWriteExclusive: assert property (@(posedge CLOCK_50) disable iff (!arstN)
        !(busReq.readEnable && busReq.writeEnable));

endmodule

/* design/stopwatch.sv */
/*
 * Microsecond stopwatch. A prescaler divides CLOCK_50 down to one count
 * per microsecond; a bus write to the stopwatch restarts it from zero.
 */
`timescale 1ns/10ps

module stopwatch import deBoardPkg::*; (
    input  logic        CLOCK_50,
    input  logic        arstN,
    input  logic        clear,
    output logic [31:0] count
);

    localparam int prescaleBits = $clog2(cyclesPerUs);

    logic [prescaleBits-1:0] prescale;
    logic                    usDone;

    // last cycle of the current microsecond
    assign usDone = (prescale == prescaleBits'(cyclesPerUs - 1));

    always_ff @(posedge CLOCK_50 or negedge arstN) begin
        if (!arstN) begin
            prescale <= '0;
        end else if (clear || usDone) begin
            prescale <= '0;
        end else begin
            prescale <= prescale + 1'b1;
        end
    end

    // free running count, wraps after about 71 minutes
    always_ff @(posedge CLOCK_50 or negedge arstN) begin
        if (!arstN) begin
            count <= '0;
        end else if (clear) begin
            count <= '0;
        end else if (usDone) begin
            count <= count + 32'd1;
        end
    end

endmodule

/* design/lfsrGen.sv */
/*
 * 32-bit Galois LFSR random source. A bus write seeds it by byte lanes and
 * every bus read steps it once after the current value has been sampled.
 */
`timescale 1ns/10ps

module lfsrGen import deBoardPkg::*; (
    input  logic        CLOCK_50,
    input  logic        arstN,
    input  logic        load,
    input  logic        advance,
    input  logic [31:0] seed,
    input  logic [3:0]  byteEnable,
    output logic [31:0] state
);

    logic [31:0] seeded;
    logic [31:0] stepped;

    assign seeded = mergeBytes(state, seed, byteEnable);

    // shift right, feed back the taps when bit 0 falls out
    assign stepped = {1'b0, state[31:1]} ^ (state[0] ? lfsrTaps : 32'd0);

    always_ff @(posedge CLOCK_50 or negedge arstN) begin
        if (!arstN) begin
            state <= 32'd1;
        end else if (load) begin
            // all-zero is a lock-up state
            state <= (seeded == 32'd0) ? 32'd1 : seeded;
        end else if (advance) begin
            state <= stepped;
        end
    end

    stateNeverZero: assert property (@(posedge CLOCK_50) disable iff (!arstN)
        state != 32'd0);

endmodule

/* design/breakUnit.sv */
/*
 * Breakpoint unit. Holds the breakpoint address and enable, watches the
 * monitored pc and sends one halt pulse to clock control per new match.
 * breakCtrl reads back as {hit, enable} in bits 1 and 0.
 */
`timescale 1ns/10ps

module breakUnit import deBoardPkg::*; (
    input  logic        CLOCK_50,
    input  logic        arstN,
    input  busReqT      busReq,
    input  periphSelT   writeSel,
    input  logic [31:0] pc,
    output logic [31:0] breakAddr,
    output logic [31:0] breakCtrl,
    output logic        halt
);

    logic enable;
    logic hit;
    logic match;
    logic matchLast;

    always_ff @(posedge CLOCK_50 or negedge arstN) begin
        if (!arstN) begin
            breakAddr <= '0;
            enable    <= 1'b0;
        end else if (writeSel == selBreakAddr) begin
            breakAddr <= mergeBytes(breakAddr, busReq.writeData, busReq.byteEnable);
        end else if (writeSel == selBreakCtrl && busReq.byteEnable[0]) begin
            // only the enable bit is writable
            enable <= busReq.writeData[0];
        end
    end

    assign match = enable && (pc == breakAddr);

    // rising match gives hit and halt one cycle later
    always_ff @(posedge CLOCK_50 or negedge arstN) begin
        if (!arstN) begin
            matchLast <= 1'b0;
            halt      <= 1'b0;
            hit       <= 1'b0;
        end else begin
            matchLast <= match;
            halt      <= match && !matchLast;
            if (match && !matchLast) begin
                hit <= 1'b1;
            end else if (writeSel == selBreakCtrl) begin
                // any control write clears the sticky flag
                hit <= 1'b0;
            end
        end
    end

    assign breakCtrl = {30'd0, hit, enable};

endmodule

/* design/displayMux.sv */
/*
 * Seven-segment display driver. Picks the monitored word named by sw[9:8]
 * and decodes its low 24 bits into six active-low hex digits.
 */
`timescale 1ns/10ps

module displayMux import deBoardPkg::*; (
    input  displaySrcT  sw,
    input  logic [31:0] pc,
    input  logic [31:0] instr,
    input  logic [31:0] debug,
    output hexDigitsT   hex
);

    logic [31:0] shown;

    // segment order is g..a from bit 6 down, low lights a segment
    function automatic logic [6:0] segOf(input logic [3:0] nibble);
        case (nibble)
            4'h0:    segOf = 7'b1000000;
            4'h1:    segOf = 7'b1111001;
            4'h2:    segOf = 7'b0100100;
            4'h3:    segOf = 7'b0110000;
            4'h4:    segOf = 7'b0011001;
            4'h5:    segOf = 7'b0010010;
            4'h6:    segOf = 7'b0000010;
            4'h7:    segOf = 7'b1111000;
            4'h8:    segOf = 7'b0000000;
            4'h9:    segOf = 7'b0010000;
            4'hA:    segOf = 7'b0001000;
            4'hB:    segOf = 7'b0000011;
            4'hC:    segOf = 7'b1000110;
            4'hD:    segOf = 7'b0100001;
            4'hE:    segOf = 7'b0000110;
            default: segOf = 7'b0001110;
        endcase
    endfunction

    always_comb begin
        case (sw)
            dispPc:    shown = pc;
            dispInstr: shown = instr;
            dispDebug: shown = debug;
            default:   shown = 32'd0;
        endcase
    end

    // upper byte does not fit on six digits
    always_comb begin
        for (int i = 0; i < 6; i++) begin
            hex[i] = segOf(shown[4*i +: 4]);
        end
    end

endmodule

/* design/topDe.sv */
/*
 * Board-level wrapper around the CPU's peripheral side. The CPU drives the
 * data bus and the monitored pc, instr and debug words from outside; this
 * level connects the bus decoder, the peripherals, clock control and the
 * board indicators.
 */
`timescale 1ns/10ps

module topDe import deBoardPkg::*; (
    input  logic        CLOCK_50,
    input  logic        arstN,
    input  logic [3:0]  key,
    input  logic [9:0]  sw,
    input  logic [31:0] pc,
    input  logic [31:0] instr,
    input  logic [31:0] debug,
    input  busReqT      busReq,
    output logic [31:0] readData,
    output hexDigitsT   hex,
    output logic [9:0]  ledr
);

    periphSelT   readSel;
    periphSelT   writeSel;
    logic [31:0] stopwatchCount;
    logic [31:0] lfsrState;
    logic [31:0] breakAddr;
    logic [31:0] breakCtrl;
    logic        halt;
    logic        tick;
    runModeT     mode;

    busDecoder busDecoder_i (
        .CLOCK_50      (CLOCK_50),
        .arstN         (arstN),
        .busReq        (busReq),
        .stopwatchData (stopwatchCount),
        .lfsrData      (lfsrState),
        .breakAddrData (breakAddr),
        .breakCtrlData (breakCtrl),
        .readSel       (readSel),
        .writeSel      (writeSel),
        .readData      (readData)
    );

    // any stopwatch write restarts it, data ignored
    stopwatch stopwatch_i (
        .CLOCK_50 (CLOCK_50),
        .arstN    (arstN),
        .clear    (writeSel == selStopwatch),
        .count    (stopwatchCount)
    );

    lfsrGen lfsrGen_i (
        .CLOCK_50   (CLOCK_50),
        .arstN      (arstN),
        .load       (writeSel == selLfsr),
        .advance    (readSel == selLfsr),
        .seed       (busReq.writeData),
        .byteEnable (busReq.byteEnable),
        .state      (lfsrState)
    );

    breakUnit breakUnit_i (
        .CLOCK_50  (CLOCK_50),
        .arstN     (arstN),
        .busReq    (busReq),
        .writeSel  (writeSel),
        .pc        (pc),
        .breakAddr (breakAddr),
        .breakCtrl (breakCtrl),
        .halt      (halt)
    );

    // sw[4:0] sets the run divider
    clockControl clockControl_i (
        .CLOCK_50 (CLOCK_50),
        .arstN    (arstN),
        .key      (key),
        .divisor  (sw[4:0]),
        .halt     (halt),
        .tick     (tick),
        .mode     (mode)
    );

    displayMux displayMux_i (
        .sw    (displaySrcT'(sw[9:8])),
        .pc    (pc),
        .instr (instr),
        .debug (debug),
        .hex   (hex)
    );

    // tick, run and halted lamps
    assign ledr = {7'd0, mode == modeHalted, mode == modeRun, tick};

endmodule

/* tb/topDeChecker.sv */
/*
 * Checker for the board wrapper testbench. Watches the DUT ports, derives
 * expected values from the bus, LFSR, stopwatch, display and tick rules,
 * counts checks and errors and prints the count line on request.
 */
`timescale 1ns/10ps

module topDeChecker import deBoardPkg::*; (
    input  logic        CLOCK_50,
    input  logic        arstN,
    input  logic [9:0]  sw,
    input  logic [31:0] pc,
    input  logic [31:0] instr,
    input  logic [31:0] debug,
    input  logic [31:0] readData,
    input  hexDigitsT   hex,
    input  logic [9:0]  ledr,
    input  logic        checkStrobe,
    input  logic [7:0]  checkKind,
    input  logic [31:0] expValue,
    output int          errorCount
);

    // active-low segments, g..a, digits 0..F
    localparam logic [6:0] segTable [16] = '{
        7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
        7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E
    };

    int          errors    = 0;
    int          checks    = 0;
    int          tickCount = 0;
    logic [31:0] lfsrModel = 32'd1;

    assign errorCount = errors;

    // galois step, taps applied when bit 0 shifts out
    function automatic logic [31:0] lfsrStep(input logic [31:0] value);
        logic [31:0] shifted;
        shifted = value >> 1;
        if (value[0]) begin
            shifted = shifted ^ lfsrTaps;
        end
        return shifted;
    endfunction

    function automatic logic [41:0] segmentsFor(input logic [31:0] word);
        logic [41:0] segs;
        for (int i = 0; i < 6; i++) begin
            segs[7*i +: 7] = segTable[word[4*i +: 4]];
        end
        return segs;
    endfunction

    task automatic compare(input string what, input logic [31:0] got,
                           input logic [31:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("Mismatch at %0t: %s, got %h, expected %h", $time, what, got, want);
        end
    endtask

    always @(posedge CLOCK_50) begin
        logic [31:0] shown;
        int          want;
        int          diff;
        if (arstN) begin
            // tick lamp counted on every edge
            if (checkStrobe && checkKind == "c") begin
                tickCount = 0;
            end else if (ledr[0]) begin
                tickCount++;
            end
            if (checkStrobe) begin
                case (checkKind)
                    "r": compare("bus read data", readData, expValue);
                    "l": begin
                        compare("LFSR seed readback", readData, expValue);
                        lfsrModel = lfsrStep(expValue);
                    end
                    "n": begin
                        compare("LFSR next state", readData, lfsrModel);
                        lfsrModel = lfsrStep(lfsrModel);
                    end
                    "s": begin
                        checks++;
                        want = int'(expValue) / cyclesPerUs;
                        diff = int'(readData) - want;
                        if (diff > 1 || diff < -1) begin
                            errors++;
                            $display("Mismatch at %0t: stopwatch read %0d, expected %0d +-1",
                                     $time, readData, want);
                        end
                    end
                    "h": begin
                        checks++;
                        case (sw[9:8])
                            2'd1:    shown = debug;
                            2'd2:    shown = instr;
                            2'd3:    shown = pc;
                            default: shown = 32'd0;
                        endcase
                        if (hex !== segmentsFor(shown)) begin
                            errors++;
                            $display("Mismatch at %0t: hex digits %h, expected word %h",
                                     $time, hex, shown[23:0]);
                        end
                    end
                    "t": begin
                        // one tick every divisor+1 cycles
                        checks++;
                        want = int'(expValue) / (int'(sw[4:0]) + 1);
                        diff = tickCount - want;
                        if (diff > 1 || diff < -1) begin
                            errors++;
                            $display("Mismatch at %0t: %0d ticks, expected %0d +-1",
                                     $time, tickCount, want);
                        end
                    end
                    "e": compare("tick count", tickCount, expValue);
                    "L": compare("indicator LEDs", 32'(ledr & 10'h3FE), expValue & 32'h3FE);
                    "o": begin
                        errors++;
                        $display("Timeout: ledr never reached its level, case line %0d",
                                 expValue);
                    end
                    "R": $display("Checker summary: %0d checks, %0d errors", checks, errors);
                    default: ;
                endcase
            end
        end
    end

endmodule

/* tb/topDeTb.sv */
/*
 * Testbench for the board wrapper. Plays the CPU side. It reads one case per
 * line from tb/topDeCases.txt, drives the data bus, keys, switches and the
 * monitored words, and hands each expected value to the checker.
 */
`timescale 1ns/10ps

module topDeTb import deBoardPkg::*; ();

    logic        CLOCK_50 = 1'b0;
    logic        arstN;
    logic [3:0]  key;
    logic [9:0]  sw;
    logic [31:0] pc;
    logic [31:0] instr;
    logic [31:0] debug;
    busReqT      busReq;
    logic [31:0] readData;
    hexDigitsT   hex;
    logic [9:0]  ledr;

    // checker request sampled on the next rising edge
    logic        checkStrobe;
    logic [7:0]  checkKind;
    logic [31:0] expValue;
    int          errorCount;
    int          setupErrors = 0;

    always #10 CLOCK_50 = ~CLOCK_50;

    topDe topDe_i (
        .CLOCK_50 (CLOCK_50),
        .arstN    (arstN),
        .key      (key),
        .sw       (sw),
        .pc       (pc),
        .instr    (instr),
        .debug    (debug),
        .busReq   (busReq),
        .readData (readData),
        .hex      (hex),
        .ledr     (ledr)
    );

    topDeChecker topDeChecker_i (
        .CLOCK_50    (CLOCK_50),
        .arstN       (arstN),
        .sw          (sw),
        .pc          (pc),
        .instr       (instr),
        .debug       (debug),
        .readData    (readData),
        .hex         (hex),
        .ledr        (ledr),
        .checkStrobe (checkStrobe),
        .checkKind   (checkKind),
        .expValue    (expValue),
        .errorCount  (errorCount)
    );

    // inputs change 1 ns after the rising edge
    task automatic nextCycle();
        @(posedge CLOCK_50);
        #1;
    endtask

    task automatic requestCheck(input logic [7:0] kind, input logic [31:0] value);
        checkKind   = kind;
        expValue    = value;
        checkStrobe = 1'b1;
        nextCycle();
        checkStrobe = 1'b0;
    endtask

    task automatic busWrite(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] be);
        busReq.addr        = addr;
        busReq.writeData   = data;
        busReq.byteEnable  = be;
        busReq.writeEnable = 1'b1;
        nextCycle();
        busReq.writeEnable = 1'b0;
    endtask

    // returns once readData holds the answer
    task automatic busRead(input logic [31:0] addr);
        busReq.addr       = addr;
        busReq.readEnable = 1'b1;
        nextCycle();
        busReq.readEnable = 1'b0;
    endtask

    // keys are active low and the release leaves room for the synchronizer
    task automatic pressKey(input logic [1:0] idx);
        key[idx] = 1'b0;
        repeat (4) nextCycle();
        key[idx] = 1'b1;
        repeat (syncStages + 4) nextCycle();
    endtask

    task automatic waitForLed(input int bitIdx, input logic level, input int limit,
                              input int lineNo);
        int waited;
        waited = 0;
        while (ledr[bitIdx] != level && waited < limit) begin
            nextCycle();
            waited++;
        end
        if (ledr[bitIdx] != level) begin
            requestCheck("o", lineNo);
        end
    endtask

    task automatic applyCase(input string op, input logic [31:0] arg,
                             input logic [31:0] data, input logic [31:0] expected,
                             input int lineNo);
        logic [31:0] randSeed;
        if (op == "write") begin
            busWrite(arg, data, expected[3:0]);
        end else if (op == "read") begin
            busRead(arg);
            requestCheck("r", expected);
        end else if (op == "lfsrread") begin
            busRead(lfsrAddr);
            requestCheck("l", expected);
        end else if (op == "lfsrrand") begin
            randSeed = $urandom;
            busWrite(lfsrAddr, randSeed, 4'hF);
            busRead(lfsrAddr);
            // zero seed comes back as one
            requestCheck("l", (randSeed == 32'd0) ? 32'd1 : randSeed);
        end else if (op == "lfsrstep") begin
            repeat (arg) begin
                busRead(lfsrAddr);
                requestCheck("n", 32'd0);
            end
        end else if (op == "swread") begin
            busRead(stopwatchAddr);
            requestCheck("s", arg);
        end else if (op == "wait") begin
            repeat (arg) nextCycle();
        end else if (op == "key") begin
            pressKey(arg[1:0]);
        end else if (op == "sw") begin
            sw = arg[9:0];
            nextCycle();
        end else if (op == "pc") begin
            pc = arg;
            nextCycle();
        end else if (op == "instr") begin
            instr = arg;
            nextCycle();
        end else if (op == "debug") begin
            debug = arg;
            nextCycle();
        end else if (op == "show") begin
            sw[9:8] = arg[1:0];
            nextCycle();
            requestCheck("h", 32'd0);
        end else if (op == "led") begin
            requestCheck("L", expected);
        end else if (op == "ledwait") begin
            waitForLed(int'(arg), data[0], int'(expected), lineNo);
        end else if (op == "tclr") begin
            requestCheck("c", 32'd0);
        end else if (op == "ticks") begin
            // clear then count over arg cycles and compare with the run rate
            requestCheck("c", 32'd0);
            repeat (arg) nextCycle();
            requestCheck("t", arg);
        end else if (op == "texact") begin
            requestCheck("e", expected);
        end else begin
            $display("Unknown operation %s on case line %0d", op, lineNo);
            setupErrors++;
        end
    endtask

    initial begin
        int          fd;
        int          lineNo;
        int          fields;
        string       line;
        string       op;
        logic [31:0] arg;
        logic [31:0] data;
        logic [31:0] expected;

        void'($urandom(88));
        key         = '1;
        sw          = '0;
        pc          = '0;
        instr       = '0;
        debug       = '0;
        busReq      = '0;
        checkStrobe = 1'b0;
        checkKind   = 8'd0;
        expValue    = '0;
        arstN       = 1'b0;
        repeat (10) @(posedge CLOCK_50);
        #1;
        arstN = 1'b1;
        nextCycle();

        fd = $fopen("tb/topDeCases.txt", "r");
        if (fd == 0) begin
            $display("Could not open the case file tb/topDeCases.txt");
            setupErrors++;
        end else begin
            lineNo = 0;
            while ($fgets(line, fd) != 0) begin
                lineNo++;
                // skip comments and blank lines
                if (line.len() > 1 && line.getc(0) != "#") begin
                    fields = $sscanf(line, "%s %h %h %h", op, arg, data, expected);
                    if (fields == 4) begin
                        applyCase(op, arg, data, expected, lineNo);
                    end else begin
                        $display("Malformed case line %0d", lineNo);
                        setupErrors++;
                    end
                end
            end
            $fclose(fd);
        end

        requestCheck("R", 32'd0);
        nextCycle();
        if (errorCount == 0 && setupErrors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // guard against a run that never ends
    initial begin
        #2000000;
        $display("Simulation ran past its time limit");
        $display("TEST FAILED");
        $finish;
    end

endmodule

/* tb/topDeCases.txt */
# op arg data expected, all numbers hex; write: arg=addr, expected=byte enables
# ledwait: arg=led bit, data=level, expected=timeout cycles
led 0 0 2
write FF200514 0 F
lfsrread 0 0 1
lfsrstep 5 0 0
write FF200514 1234ABCD F
lfsrread 0 0 1234ABCD
lfsrstep 5 0 0
lfsrrand 0 0 0
lfsrstep 5 0 0
lfsrrand 0 0 0
lfsrstep 5 0 0
write FF200600 11223344 F
write FF200600 AABBCCDD 5
read FF200600 0 11BB33DD
write FF200600 EE000000 8
read FF200600 0 EEBB33DD
read FF200700 0 0
write FF200510 0 F
wait 3E8 0 0
swread 3E8 0 0
pc 00ABCDEF 0 0
instr 00123456 0 0
debug 789ABC00 0 0
show 0 0 0
show 1 0 0
show 2 0 0
show 3 0 0
sw 004 0 0
ticks 1F4 0 0
sw 009 0 0
ticks 1F4 0 0
write FF200600 1000 F
write FF200604 1 F
pc 1000 0 0
ledwait 2 1 14
led 0 0 4
tclr 0 0 0
wait C8 0 0
texact 0 0 0
read FF200604 0 3
write FF200604 1 F
read FF200604 0 1
key 3 0 0
ledwait 2 0 14
ticks 1F4 0 0
key 1 0 0
led 0 0 0
tclr 0 0 0
key 2 0 0
key 2 0 0
key 2 0 0
texact 0 0 3

/* topDe.f */
design/deBoardPkg.sv
design/clockControl.sv
design/busDecoder.sv
design/stopwatch.sv
design/lfsrGen.sv
design/breakUnit.sv
design/displayMux.sv
design/topDe.sv
tb/topDeChecker.sv
tb/topDeTb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = topDeTb
FILELIST  = topDe.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	./$(OBJDIR)/V$(TOP) > $(LOG)
	@cat $(LOG)
	@grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
